/* rtl/ws2812_frame_timer.sv */
module ws2812_frame_timer (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  ws2812_pkg::channel_t  channel,
    output ws2812_pkg::slot_t     slot
);

    ws2812_pkg::channel_t                channel_q;
    logic [ws2812_pkg::GAP_W-1:0]        gap_cnt;
    logic                                active_q;
    logic [ws2812_pkg::PHASE_W-1:0]      phase_q;
    logic [ws2812_pkg::IDX_W-1:0]        bit_idx_q;
    logic [ws2812_pkg::IDX_W-1:0]        led_idx_q;
    logic                                chan_change;
    logic                                gap_last;
    logic                                slot_last;

    assign chan_change = (channel != channel_q);
    assign gap_last    = (gap_cnt == ws2812_pkg::LAST_GAP);
    assign slot_last   = (phase_q == ws2812_pkg::LAST_PHASE);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            channel_q <= '0;
            gap_cnt   <= '0;
            active_q  <= 1'b0;
            phase_q   <= '0;
            bit_idx_q <= ws2812_pkg::TOP_BIT;
            led_idx_q <= '0;
        end else begin
            channel_q <= channel;
            if (chan_change) begin
                // new channel, start over with a full gap
                gap_cnt   <= '0;
                active_q  <= 1'b0;
                phase_q   <= '0;
                bit_idx_q <= ws2812_pkg::TOP_BIT;
                led_idx_q <= '0;
            end else if (!active_q) begin
                if (gap_last) begin
                    gap_cnt  <= '0;
                    active_q <= 1'b1;
                end else begin
                    gap_cnt <= gap_cnt + 1'b1;
                end
            end else if (slot_last) begin
                phase_q <= '0;
                if (bit_idx_q == '0) begin
                    bit_idx_q <= ws2812_pkg::TOP_BIT;
                    if (led_idx_q == ws2812_pkg::LAST_LED) begin
                        led_idx_q <= '0;
                        active_q  <= 1'b0;  // frame done, back to the gap
                    end else begin
                        led_idx_q <= led_idx_q + 1'b1;
                    end
                end else begin
                    bit_idx_q <= bit_idx_q - 1'b1;
                end
            end else begin
                phase_q <= phase_q + 1'b1;
            end
        end
    end

    // a pending channel change masks the old frame right away
    assign slot.active      = active_q & ~chan_change;
    assign slot.frame_start = ~active_q & gap_last & ~chan_change;
    assign slot.phase       = phase_q;
    assign slot.bit_idx     = bit_idx_q;
    assign slot.led_idx     = led_idx_q;

    a_bit_idx_range: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        bit_idx_q <= ws2812_pkg::TOP_BIT
    );

    // every frame opens on the MSB of the first LED
    a_frame_start_then_active: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        slot.frame_start |-> !slot.active ##1
            (active_q && phase_q == '0 && bit_idx_q == ws2812_pkg::TOP_BIT
             && led_idx_q == '0)
    );

endmodule

/* rtl/ws2812_line_driver.sv */
module ws2812_line_driver (
    input  logic                                 sys_clk,
    input  logic                                 sys_rst_n,
    input  ws2812_pkg::channel_t                 channel,
    input  ws2812_pkg::slot_t                    slot,
    input  ws2812_pkg::chain_bits_t              bits,
    output logic [ws2812_pkg::NUM_CHANNELS-1:0]  led_a,
    output logic [ws2812_pkg::NUM_CHANNELS-1:0]  led_b
);

    logic                                 pulse_a;
    logic                                 pulse_b;
    logic [ws2812_pkg::NUM_CHANNELS-1:0]  next_a;
    logic [ws2812_pkg::NUM_CHANNELS-1:0]  next_b;

    // return-to-zero level for one chain at the current phase
    function automatic logic rz_level(
        input logic                           active,
        input logic [ws2812_pkg::PHASE_W-1:0] phase,
        input logic                           data
    );
        logic [ws2812_pkg::PHASE_W-1:0] high_len;
        high_len = data ? ws2812_pkg::PHASE_W'(ws2812_pkg::T1_HIGH)
                        : ws2812_pkg::PHASE_W'(ws2812_pkg::T0_HIGH);
        return active && (phase < high_len);
    endfunction

    assign pulse_a = rz_level(slot.active, slot.phase, bits.a);
    assign pulse_b = rz_level(slot.active, slot.phase, bits.b);

    always_comb begin
        next_a = '1;  // idle lines sit high
        next_b = '1;
        if (channel < ws2812_pkg::NUM_CHANNELS) begin
            next_a[channel] = pulse_a;
            next_b[channel] = pulse_b;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            led_a <= '0;
            led_b <= '0;
        end else begin
            led_a <= next_a;
            led_b <= next_b;
        end
    end

    // only the selected line may ever be pulled low
    a_one_low_line: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        (channel < ws2812_pkg::NUM_CHANNELS) |=> ($countones(~led_a) <= 1)
    );

endmodule

/* rtl/ws2812_pixel_buffer.sv */
module ws2812_pixel_buffer (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  ws2812_pkg::pixel_bus_t    pixels,
    input  ws2812_pkg::slot_t         slot,
    output ws2812_pkg::chain_bits_t   bits
);

    ws2812_pkg::pixel_bus_t                snap;
    logic [ws2812_pkg::LVL_IDX_W-1:0]      idx_a;
    logic [ws2812_pkg::LVL_IDX_W-1:0]      idx_b;
    ws2812_pkg::level_t                    level_a;
    ws2812_pkg::level_t                    level_b;
    logic [ws2812_pkg::COLOR_W-1:0]        word_a;
    logic [ws2812_pkg::COLOR_W-1:0]        word_b;

    // one copy per frame, bus may move freely while bits go out
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            snap <= '0;
        end else if (slot.frame_start) begin
            snap <= pixels;
        end
    end

    assign idx_a = {1'b0, slot.led_idx};
    assign idx_b = ws2812_pkg::LAST_LEVEL - {1'b0, slot.led_idx};  // chain b wired in reverse

    assign level_a = snap[idx_a];
    assign level_b = snap[idx_b];

    assign word_a = {3{level_a}};
    assign word_b = {3{level_b}};

    assign bits.a = word_a[slot.bit_idx];  // msb first
    assign bits.b = word_b[slot.bit_idx];

endmodule

/* rtl/ws2812_pkg.sv */
package ws2812_pkg;

    localparam int NUM_CHANNELS   = 20;
    localparam int LEDS_PER_CHAIN = 20;
    localparam int NUM_LEVELS     = 2 * LEDS_PER_CHAIN;  // chain a levels, then chain b levels
    localparam int LEVEL_W        = 8;
    localparam int COLOR_W        = 3 * LEVEL_W;         // same gray on all three colours
    localparam int BIT_CYCLES     = 68;
    localparam int T0_HIGH        = 17;
    localparam int T1_HIGH        = 51;
    localparam int RESET_CYCLES   = 5000;                // latch gap, well over 50 us

    localparam int CHANNEL_W = 5;
    localparam int PHASE_W   = 7;
    localparam int IDX_W     = 5;
    localparam int LVL_IDX_W = $clog2(NUM_LEVELS);
    localparam int GAP_W     = $clog2(RESET_CYCLES);

    localparam logic [PHASE_W-1:0]   LAST_PHASE = PHASE_W'(BIT_CYCLES - 1);
    localparam logic [IDX_W-1:0]     TOP_BIT    = IDX_W'(COLOR_W - 1);
    localparam logic [IDX_W-1:0]     LAST_LED   = IDX_W'(LEDS_PER_CHAIN - 1);
    localparam logic [LVL_IDX_W-1:0] LAST_LEVEL = LVL_IDX_W'(NUM_LEVELS - 1);
    localparam logic [GAP_W-1:0]     LAST_GAP   = GAP_W'(RESET_CYCLES - 1);

    typedef logic [LEVEL_W-1:0] level_t;
    typedef level_t [NUM_LEVELS-1:0] pixel_bus_t;  // level k at bits 8k+7:8k
    typedef logic [CHANNEL_W-1:0] channel_t;

    typedef struct packed {
        logic               active;       // bits on the wire
        logic               frame_start;  // last gap cycle
        logic [PHASE_W-1:0] phase;
        logic [IDX_W-1:0]   bit_idx;      // 23 down to 0
        logic [IDX_W-1:0]   led_idx;
    } slot_t;

    typedef struct packed {
        logic a;
        logic b;
    } chain_bits_t;

endpackage

/* rtl/ws2812_strip.sv */
module ws2812_strip (
    input  logic                                 sys_clk,
    input  logic                                 sys_rst_n,
    input  ws2812_pkg::pixel_bus_t               pixels,
    input  ws2812_pkg::channel_t                 channel,
    output logic [ws2812_pkg::NUM_CHANNELS-1:0]  led_a,
    output logic [ws2812_pkg::NUM_CHANNELS-1:0]  led_b
);

    ws2812_pkg::slot_t        slot;
    ws2812_pkg::chain_bits_t  bits;

    // gap and bit slot sequencing
    ws2812_frame_timer timer_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .channel   (channel),
        .slot      (slot)
    );

    ws2812_pixel_buffer buffer_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .pixels    (pixels),
        .slot      (slot),
        .bits      (bits)
    );

    ws2812_line_driver driver_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .channel   (channel),
        .slot      (slot),
        .bits      (bits),
        .led_a     (led_a),
        .led_b     (led_b)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the WS2812 strip testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module ws2812_strip_tb \
    --Mdir obj_dir -o ws2812_strip_sim \
    -f ws2812_strip.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/ws2812_strip_sim)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "simulation did not report a clean run"
exit 1

/* verification/strip_input.txt */
# channel (decimal)  pixel bus (80 hex digits, level 39 first, level 0 last)  mid-frame flag
# flag 1 swaps the bus for its inverse halfway through the first frame
3 27262524232221201f1e1d1c1b1a191817161514131211100f0e0d0c0b0a09080706050403020100 0
3 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef 0
0 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0
19 00000000000000000000000000000000000000000000000000000000000000000000000000000000 0
19 27262524232221201f1e1d1c1b1a191817161514131211100f0e0d0c0b0a09080706050403020100 1
20 deadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeef 0
7 deadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeefdeadbeef 0
7 80402010080402018040201008040201804020100804020180402010080402018040201008040201 0
12 55aa33cc55aa33cc55aa33cc55aa33cc55aa33cc55aa33cc55aa33cc55aa33cc55aa33cc55aa33cc 0
31 fedcba9876543210fedcba9876543210fedcba9876543210fedcba9876543210fedcba9876543210 0
12 fedcba9876543210fedcba9876543210fedcba9876543210fedcba9876543210fedcba9876543210 1
1 00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff 0
18 13579bdf2468ace013579bdf2468ace013579bdf2468ace013579bdf2468ace013579bdf2468ace0 0
20 c0ffee11c0ffee11c0ffee11c0ffee11c0ffee11c0ffee11c0ffee11c0ffee11c0ffee11c0ffee11 0
5 c0ffee11c0ffee11c0ffee11c0ffee11c0ffee11c0ffee11c0ffee11c0ffee11c0ffee11c0ffee11 0
5 7f01fe807f01fe807f01fe807f01fe807f01fe807f01fe807f01fe807f01fe807f01fe807f01fe80 1
9 b7e15162b7e15162b7e15162b7e15162b7e15162b7e15162b7e15162b7e15162b7e15162b7e15162 0
14 243f6a88243f6a88243f6a88243f6a88243f6a88243f6a88243f6a88243f6a88243f6a88243f6a88 0
2 9e3779b99e3779b99e3779b99e3779b99e3779b99e3779b99e3779b99e3779b99e3779b99e3779b9 0
16 a5c3e10fa5c3e10fa5c3e10fa5c3e10fa5c3e10fa5c3e10fa5c3e10fa5c3e10fa5c3e10fa5c3e10f 0
0 27262524232221201f1e1d1c1b1a191817161514131211100f0e0d0c0b0a09080706050403020100 0
19 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef 0

/* verification/ws2812_strip_tb.sv */
module ws2812_strip_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SLOTS     = ws2812_pkg::LEDS_PER_CHAIN * ws2812_pkg::COLOR_W;
    localparam int FRAME_CYCLES  = ws2812_pkg::RESET_CYCLES + NUM_SLOTS * ws2812_pkg::BIT_CYCLES;
    localparam int GAP_LIMIT     = 2 * FRAME_CYCLES + 100;
    localparam int MIDFRAME_SLOT = NUM_SLOTS / 2;
    localparam int BUS_W         = ws2812_pkg::NUM_LEVELS * ws2812_pkg::LEVEL_W;

    logic                                 sys_clk;
    logic                                 sys_rst_n;
    ws2812_pkg::pixel_bus_t               pixels;
    ws2812_pkg::channel_t                 channel;
    logic [ws2812_pkg::NUM_CHANNELS-1:0]  led_a;
    logic [ws2812_pkg::NUM_CHANNELS-1:0]  led_b;

    int                    mismatch_cnt;
    int                    failure_cnt;
    logic                  timed_out;
    logic                  monitor_on;
    ws2812_pkg::channel_t  seen_ch;
    ws2812_pkg::channel_t  old_ch;
    int                    grace;

    always #20 sys_clk = ~sys_clk;

    ws2812_strip dut_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .pixels    (pixels),
        .channel   (channel),
        .led_a     (led_a),
        .led_b     (led_b)
    );

    task automatic compare(input logic [31:0] got, input logic [31:0] expected,
                           input string what);
        if (got !== expected) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic report_failure(input string what);
        failure_cnt++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    // unselected lines must sit high and the old channel gets two cycles to let go
    always @(negedge sys_clk) begin
        logic [ws2812_pkg::NUM_CHANNELS-1:0] idle_mask;
        if (monitor_on) begin
            if (channel != seen_ch) begin
                old_ch  = seen_ch;
                grace   = 2;
                seen_ch = channel;
            end
            idle_mask = '1;
            if (channel < ws2812_pkg::NUM_CHANNELS) begin
                idle_mask[channel] = 1'b0;
            end
            if (grace > 0) begin
                if (old_ch < ws2812_pkg::NUM_CHANNELS) begin
                    idle_mask[old_ch] = 1'b0;
                end
                grace--;
            end
            compare(32'(led_a & idle_mask), 32'(idle_mask), "idle lines of chain A");
            compare(32'(led_b & idle_mask), 32'(idle_mask), "idle lines of chain B");
        end
    end

    // a rising edge after a long low run marks the first bit of a frame
    task automatic wait_frame_start(input int ch, input logic changed, output logic found);
        int   low_run;
        int   cycles;
        logic prev;
        logic level;
        logic first_edge;
        low_run    = 0;
        prev       = 1'b1;
        first_edge = 1'b1;
        found      = 1'b0;
        for (cycles = 0; cycles < GAP_LIMIT; cycles++) begin
            @(negedge sys_clk);
            level = led_a[ch];
            if (!level) begin
                low_run++;
            end else if (!prev) begin
                if (changed && first_edge && low_run < ws2812_pkg::RESET_CYCLES) begin
                    report_failure($sformatf(
                        "channel %0d rose after only %0d low cycles following a channel change",
                        ch, low_run));
                end
                first_edge = 1'b0;
                if (low_run >= ws2812_pkg::RESET_CYCLES) begin
                    found = 1'b1;
                    return;
                end
                low_run = 0;
            end
            prev = level;
        end
        timed_out = 1'b1;
        report_failure($sformatf("timed out waiting for a frame on channel %0d", ch));
    endtask

    // called on the first high sample of a frame
    task automatic decode_frame(input int ch, input int change_slot,
                                input ws2812_pkg::pixel_bus_t next_pix,
                                output logic [NUM_SLOTS-1:0] got_a,
                                output logic [NUM_SLOTS-1:0] got_b);
        int   hi_a;
        int   hi_b;
        logic fell_a;
        logic fell_b;
        logic bad_a;
        logic bad_b;
        logic la;
        logic lb;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            hi_a   = 0;
            hi_b   = 0;
            fell_a = 1'b0;
            fell_b = 1'b0;
            bad_a  = 1'b0;
            bad_b  = 1'b0;
            for (int c = 0; c < ws2812_pkg::BIT_CYCLES; c++) begin
                if (s != 0 || c != 0) begin
                    @(negedge sys_clk);
                end
                la = led_a[ch];
                lb = led_b[ch];
                if (c == 0) begin
                    compare(32'({la, lb}), 32'b11, $sformatf("rising edges at slot %0d", s));
                end
                if (la) begin
                    if (fell_a) bad_a = 1'b1;
                    else hi_a++;
                end else begin
                    fell_a = 1'b1;
                end
                if (lb) begin
                    if (fell_b) bad_b = 1'b1;
                    else hi_b++;
                end else begin
                    fell_b = 1'b1;
                end
                if (s == change_slot && c == 0) begin
                    @(posedge sys_clk);
                    #2;
                    pixels = next_pix;  // bus moves while the frame is on the wire
                end
            end
            if (bad_a || (hi_a != ws2812_pkg::T0_HIGH && hi_a != ws2812_pkg::T1_HIGH)) begin
                report_failure($sformatf("chain A slot %0d has a bad pulse, %0d high cycles",
                                         s, hi_a));
            end
            if (bad_b || (hi_b != ws2812_pkg::T0_HIGH && hi_b != ws2812_pkg::T1_HIGH)) begin
                report_failure($sformatf("chain B slot %0d has a bad pulse, %0d high cycles",
                                         s, hi_b));
            end
            got_a[NUM_SLOTS-1-s] = (hi_a == ws2812_pkg::T1_HIGH);
            got_b[NUM_SLOTS-1-s] = (hi_b == ws2812_pkg::T1_HIGH);
        end
    endtask

    // chain A takes levels upward and chain B from the top level down
    task automatic check_frame(input int ch, input ws2812_pkg::pixel_bus_t pix,
                               input logic [NUM_SLOTS-1:0] got_a,
                               input logic [NUM_SLOTS-1:0] got_b);
        ws2812_pkg::level_t level_a;
        ws2812_pkg::level_t level_b;
        for (int led = 0; led < ws2812_pkg::LEDS_PER_CHAIN; led++) begin
            level_a = pix[led];
            level_b = pix[ws2812_pkg::NUM_LEVELS-1-led];
            compare(32'(got_a[NUM_SLOTS-1-ws2812_pkg::COLOR_W*led -: ws2812_pkg::COLOR_W]),
                    32'({3{level_a}}), $sformatf("channel %0d chain A led %0d", ch, led));
            compare(32'(got_b[NUM_SLOTS-1-ws2812_pkg::COLOR_W*led -: ws2812_pkg::COLOR_W]),
                    32'({3{level_b}}), $sformatf("channel %0d chain B led %0d", ch, led));
        end
    endtask

    task automatic run_case(input int ch, input ws2812_pkg::pixel_bus_t pix,
                            input logic midframe, input logic changed);
        logic                  found;
        logic [NUM_SLOTS-1:0]  got_a;
        logic [NUM_SLOTS-1:0]  got_b;
        if (ch >= ws2812_pkg::NUM_CHANNELS) begin
            repeat (4 * ws2812_pkg::BIT_CYCLES) @(negedge sys_clk);
            compare(32'(led_a), 32'({ws2812_pkg::NUM_CHANNELS{1'b1}}), "chain A out of range");
            compare(32'(led_b), 32'({ws2812_pkg::NUM_CHANNELS{1'b1}}), "chain B out of range");
            return;
        end
        wait_frame_start(ch, changed, found);
        if (!found) return;
        if (midframe) begin
            decode_frame(ch, MIDFRAME_SLOT, ~pix, got_a, got_b);
            check_frame(ch, pix, got_a, got_b);  // snapshot from frame start
            wait_frame_start(ch, 1'b0, found);
            if (!found) return;
            decode_frame(ch, -1, ~pix, got_a, got_b);
            check_frame(ch, ~pix, got_a, got_b);
        end else begin
            decode_frame(ch, -1, pix, got_a, got_b);
            check_frame(ch, pix, got_a, got_b);
        end
    endtask

    initial begin
        int                    fd;
        int                    ch_val;
        int                    flag;
        int                    case_cnt;
        string                 line;
        logic [BUS_W-1:0]      pix_val;
        ws2812_pkg::channel_t  prev_ch;
        sys_clk      = 1'b0;
        sys_rst_n    = 1'b0;
        channel      = '0;
        pixels       = '0;
        mismatch_cnt = 0;
        failure_cnt  = 0;
        timed_out    = 1'b0;
        monitor_on   = 1'b0;
        grace        = 0;
        case_cnt     = 0;
        repeat (9) @(posedge sys_clk);
        @(negedge sys_clk);
        compare(32'(led_a), 32'h0, "chain A during reset");
        compare(32'(led_b), 32'h0, "chain B during reset");
        @(posedge sys_clk);
        #2;
        sys_rst_n = 1'b1;
        @(posedge sys_clk);
        #2;
        seen_ch    = channel;
        prev_ch    = channel;
        monitor_on = 1'b1;

        fd = $fopen("verification/strip_input.txt", "r");
        if (fd == 0) begin
            report_failure("could not open verification/strip_input.txt");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                if ($fgets(line, fd) == 0) continue;
                if (line.len() < 2 || line.getc(0) == "#") continue;
                if ($sscanf(line, "%d %h %d", ch_val, pix_val, flag) != 3) begin
                    report_failure($sformatf("could not parse data line: %s", line));
                    continue;
                end
                case_cnt++;
                @(posedge sys_clk);
                #2;
                channel = ws2812_pkg::channel_t'(ch_val);
                pixels  = pix_val;
                run_case(ch_val, pix_val, flag != 0, channel != prev_ch);
                prev_ch = channel;
            end
            $fclose(fd);
        end
        if (case_cnt == 0 && !timed_out) begin
            report_failure("no test cases were read from the data file");
        end

        $display("%0d cases, %0d mismatches, %0d other errors",
                 case_cnt, mismatch_cnt, failure_cnt);
        if (mismatch_cnt == 0 && failure_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* ws2812_strip.f */
rtl/ws2812_pkg.sv
rtl/ws2812_frame_timer.sv
rtl/ws2812_pixel_buffer.sv
rtl/ws2812_line_driver.sv
rtl/ws2812_strip.sv
verification/ws2812_strip_tb.sv
